// ==== dv/frontend_patterns.hex ====
// kind_a_b_c: 1 memory (byte address, data 63:32, data 31:0), 2 redirect (count, unused, target)
// 3 expected instruction in program order (pc, instr, is16bit)
1_00000000_81130010_00934505
1_00000008_95aa4581_05050020
1_00000010_00418213_80820001
1_00000018_03134605_00520293
1_00000020_87820705_46850063
1_00000100_4b0500b5_85934a01
1_00000108_8d824c81_00c60613
1_00000200_86934f01_4e814e01
1_00000208_00e78713_500500d6
1_00000210_510500f8_07935085
2_0000000f_00000000_00000102
2_00000014_00000000_00000206
3_00000000_00004505_00000001
3_00000002_00100093_00000000
3_00000006_00208113_00000000
3_0000000a_00000505_00000001
3_0000000c_00004581_00000001
3_0000000e_000095aa_00000001
3_00000010_00000001_00000001
3_00000012_00008082_00000001
3_00000014_00418213_00000000
3_00000018_00520293_00000000
3_0000001c_00004605_00000001
3_0000001e_00630313_00000000
3_00000022_00004685_00000001
3_00000024_00000705_00000001
3_00000026_00008782_00000001
3_00000102_00b58593_00000000
3_00000106_00004b05_00000001
3_00000108_00c60613_00000000
3_0000010c_00004c81_00000001
3_0000010e_00008d82_00000001
3_00000206_00d68693_00000000
3_0000020a_00005005_00000001
3_0000020c_00e78713_00000000
3_00000210_00005085_00000001
3_00000212_00f80793_00000000
3_00000216_00005105_00000001

// ==== verilog.f ====
+incdir+include
source/FetchPkg.sv
source/DecodePkg.sv
source/PriorityEncoder.sv
source/PacketFetcher.sv
source/InstrAligner.sv
source/Frontend.sv
dv/frontend_sva.sv
dv/FrontendTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= FrontendTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -qx '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/FrontendTb.sv ====
`default_nettype none
`include "frontend_params.svh"

module FrontendTb;
    timeunit 1ns;
    timeprecision 1ps;

    import FetchPkg::*;
    import DecodePkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int PAT_DEPTH = 128;
    localparam FetchAddr RESET_ADDR = `RESET_PC;

    logic    clk;
    logic    rst;
    Redirect redirect;
    WbReq    busReq;
    WbRsp    busRsp;
    PdInstr  instrs [`NUM_INSTRS];
    logic    ready;

    // Record layout is kind in the top nibble, then three 32-bit columns
    logic [99:0] patRec [PAT_DEPTH];
    logic [63:0] memImage [PacketAddr];
    int          redirAfter [$];
    FetchAddr    redirTarget [$];
    PdInstr      expInstr [$];

    integer seed;
    int     instrErrors;
    int     busErrors;
    int     otherErrors;
    logic   patternsLoaded;

    logic [1:0] waitLeft;
    logic       prevCyc;
    logic       prevAck;
    logic       reqCheckPending;
    WbReq       expReq;

    int     expIdx;
    logic   redirPending;
    logic   groupHeld;
    PdInstr heldGroup [`NUM_INSTRS];

    Frontend dut_i (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .busReq(busReq),
        .busRsp(busRsp),
        .instrs(instrs),
        .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic loadPatterns();
        PdInstr rec;
        for (int i = 0; i < PAT_DEPTH; i++) begin
            patRec[i] = '0;
        end
        $readmemh("dv/frontend_patterns.hex", patRec);
        for (int i = 0; i < PAT_DEPTH; i++) begin
            case (patRec[i][99:96])
                4'h1: memImage[PacketAddr'(patRec[i][95:67])] = patRec[i][63:0];
                4'h2: begin
                    redirAfter.push_back(int'(patRec[i][95:64]));
                    redirTarget.push_back(patRec[i][31:0]);
                end
                4'h3: begin
                    rec.valid = 1'b1;
                    rec.pc = patRec[i][95:64];
                    rec.instr = patRec[i][63:32];
                    rec.is16bit = patRec[i][0];
                    expInstr.push_back(rec);
                end
                default: begin
                end
            endcase
        end
    endtask

    function automatic string formatInstr(PdInstr pd);
        return $sformatf("pc=%h instr=%h is16bit=%b valid=%b",
                         pd.pc, pd.instr, pd.is16bit, pd.valid);
    endfunction

    task automatic checkInstr(string name, PdInstr expected, PdInstr actual);
        if (actual !== expected) begin
            instrErrors++;
            $display("Fail %s: expected %s, actual %s",
                     name, formatInstr(expected), formatInstr(actual));
        end
    endtask

    task automatic checkBus(string name, WbReq expected, WbReq actual);
        if (actual !== expected) begin
            busErrors++;
            $display("Fail %s: expected cyc=%b stb=%b adr=%h, actual cyc=%b stb=%b adr=%h",
                     name, expected.cyc, expected.stb, expected.adr,
                     actual.cyc, actual.stb, actual.adr);
        end
    endtask

    // Packets outside the image get a fill built from every address bit
    function automatic logic [63:0] readMemory(PacketAddr adr);
        if (memImage.exists(adr)) begin
            return memImage[adr];
        end
        return {adr, 3'b101, ~adr, 3'b011};
    endfunction

    task automatic memoryStep();
        WbRsp rsp;
        logic newReq;
        rsp = '0;
        newReq = busReq.cyc && busReq.stb && (!prevCyc || prevAck);
        if (newReq) begin
            waitLeft = 2'($random(seed));
            if (reqCheckPending) begin
                checkBus("first request after reset or redirect", expReq, busReq);
                reqCheckPending = 1'b0;
            end
        end
        if (busReq.cyc && busReq.stb) begin
            if (waitLeft == 2'd0) begin
                rsp.ack = 1'b1;
                rsp.dat = readMemory(busReq.adr);
            end else begin
                waitLeft = waitLeft - 2'd1;
            end
        end
        busRsp = rsp;
        prevCyc = busReq.cyc;
        prevAck = rsp.ack;
    endtask

    // Slots taken between the redirect point and the redirect edge are wrong path
    task automatic acceptSlot(PdInstr slot);
        if (!redirPending && expIdx < expInstr.size()) begin
            checkInstr($sformatf("stream %0d", expIdx), expInstr[expIdx], slot);
            expIdx++;
            if (redirAfter.size() != 0 && expIdx == redirAfter[0]) begin
                redirPending = 1'b1;
            end
        end
    endtask

    task automatic consumerStep();
        Redirect rd;
        rd = '0;
        if (groupHeld) begin
            for (int s = 0; s < `NUM_INSTRS; s++) begin
                checkInstr($sformatf("held group slot %0d", s), heldGroup[s], instrs[s]);
            end
        end
        ready = (2'($random(seed)) != 2'd0);
        if (instrs[0].valid && ready) begin
            for (int s = 0; s < `NUM_INSTRS; s++) begin
                if (instrs[s].valid) begin
                    acceptSlot(instrs[s]);
                end
            end
        end
        // Redirect lands while the memory is inserting a wait state
        if (redirPending && busReq.cyc && !busRsp.ack) begin
            rd.valid = 1'b1;
            rd.pc = redirTarget.pop_front();
            void'(redirAfter.pop_front());
            redirPending = 1'b0;
            expReq = '{cyc: 1'b1, stb: 1'b1, adr: rd.pc[31:3]};
            reqCheckPending = 1'b1;
        end
        redirect = rd;
        groupHeld = instrs[0].valid && !ready && !rd.valid;
        for (int s = 0; s < `NUM_INSTRS; s++) begin
            heldGroup[s] = instrs[s];
        end
    endtask

    initial begin
        seed = 32'hec72ae98;
        rst = 1'b1;
        redirect = '0;
        busRsp = '0;
        ready = 1'b0;
        instrErrors = 0;
        busErrors = 0;
        otherErrors = 0;
        waitLeft = 2'd0;
        prevCyc = 1'b0;
        prevAck = 1'b0;
        expReq = '{cyc: 1'b1, stb: 1'b1, adr: RESET_ADDR[31:3]};
        reqCheckPending = 1'b1;
        expIdx = 0;
        redirPending = 1'b0;
        groupHeld = 1'b0;
        patternsLoaded = 1'b0;
        loadPatterns();
        patternsLoaded = 1'b1;
        if (expInstr.size() == 0) begin
            otherErrors++;
            $display("No expected instructions were read from the pattern file");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (expIdx < expInstr.size()) begin
            @(negedge clk);
            memoryStep();
            consumerStep();
        end
        if (redirAfter.size() != 0) begin
            otherErrors++;
            $display("%0d redirect commands were never applied", redirAfter.size());
        end
        $display("Errors: instr=%0d bus=%0d other=%0d", instrErrors, busErrors, otherErrors);
        if (instrErrors + busErrors + otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        wait (patternsLoaded === 1'b1);
        #((RESET_CYCLES + CYCLES_PER_INSTR * expInstr.size()) * CLK_PERIOD);
        $display("Timeout: only %0d of %0d expected instructions arrived",
                 expIdx, expInstr.size());
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/frontend_sva.sv ====
`default_nettype none
`include "frontend_params.svh"

module FrontendSva (
    input logic              clk,
    input logic              rst,
    input FetchPkg::Redirect redirect,
    input FetchPkg::WbReq    busReq,
    input FetchPkg::WbRsp    busRsp,
    input DecodePkg::PdInstr instrs [`NUM_INSTRS],
    input logic              ready
);
    timeunit 1ns;
    timeprecision 1ps;

    stbNeedsCyc: assert property (@(posedge clk) disable iff (rst)
        busReq.stb |-> busReq.cyc)
        else $error("Wishbone stb high without cyc");

    // Classic cycle holds until the slave acks
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (rst)
        busReq.stb && !busRsp.ack |=> busReq.stb && $stable(busReq.adr))
        else $error("Wishbone request changed before ack");

    cycDropsAfterAck: assert property (@(posedge clk) disable iff (rst)
        busReq.cyc && busRsp.ack |=> !busReq.cyc)
        else $error("Wishbone cyc still high after ack");

    busQuietInReset: assert property (@(posedge clk)
        rst |-> !busReq.cyc && !busReq.stb)
        else $error("Bus request during reset");

    for (genvar s = 0; s < `NUM_INSTRS; s++) begin : gSlot
        slotQuietInReset: assert property (@(posedge clk)
            rst |-> !instrs[s].valid)
            else $error("Output slot %0d valid during reset", s);

        groupStable: assert property (@(posedge clk) disable iff (rst)
            instrs[0].valid && !ready && !redirect.valid |=> $stable(instrs[s]))
            else $error("Output slot %0d changed while ready was low", s);

        if (s > 0) begin : gContig
            slotsContiguous: assert property (@(posedge clk) disable iff (rst)
                instrs[s].valid |-> instrs[s-1].valid)
                else $error("Output slot %0d valid above an empty slot", s);
        end
    end

endmodule

bind Frontend FrontendSva sva_i (
    .clk(clk),
    .rst(rst),
    .redirect(redirect),
    .busReq(busReq),
    .busRsp(busRsp),
    .instrs(instrs),
    .ready(ready)
);

`default_nettype wire

// ==== source/Frontend.sv ====
`default_nettype none
`include "frontend_params.svh"

module Frontend (
    input  logic              clk,
    input  logic              rst,
    input  FetchPkg::Redirect redirect,
    output FetchPkg::WbReq    busReq,
    input  FetchPkg::WbRsp    busRsp,
    output DecodePkg::PdInstr instrs [`NUM_INSTRS],
    input  logic              ready
);
    import FetchPkg::*;

    IfPacket packet;
    logic    packetReady;

    PacketFetcher fetcher_i (
        .clk(clk),
        .rst(rst),
        .redirect(redirect),
        .busReq(busReq),
        .busRsp(busRsp),
        .packet(packet),
        .packetReady(packetReady)
    );

    // Redirect also flushes everything the aligner holds
    InstrAligner #(
        .NUM_PACKETS(`NUM_PACKETS),
        .NUM_INSTRS(`NUM_INSTRS),
        .BUF_SIZE(`BUF_SIZE),
        .FF_OUTPUT(`FF_OUTPUT)
    ) aligner_i (
        .clk(clk),
        .rst(rst),
        .clear(redirect.valid),
        .packet(packet),
        .packetReady(packetReady),
        .ready(ready),
        .instrs(instrs)
    );

endmodule

`default_nettype wire

// ==== source/InstrAligner.sv ====
`default_nettype none
`include "frontend_params.svh"

module InstrAligner #(
    parameter int NUM_PACKETS = `NUM_PACKETS,
    parameter int NUM_INSTRS = `NUM_INSTRS,
    parameter int BUF_SIZE = `BUF_SIZE,
    parameter int FF_OUTPUT = `FF_OUTPUT
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  FetchPkg::IfPacket packet,
    output logic              packetReady,
    input  logic              ready,
    output DecodePkg::PdInstr instrs [NUM_INSTRS]
);
    import FetchPkg::*;
    import DecodePkg::*;

    localparam int WINDOW_SIZE = (BUF_SIZE + 1) * NUM_PACKETS;
    localparam int IDX_W = $clog2(WINDOW_SIZE);
    localparam int MID = BUF_SIZE * NUM_PACKETS - 1;
    localparam int LAST = WINDOW_SIZE - 1;

    IfPacket                                prevPkt [BUF_SIZE];
    logic [BUF_SIZE-1:0][NUM_PACKETS-1:0] prevStart;
    logic [BUF_SIZE-1:0][NUM_PACKETS-1:0] prevStart32;
    logic [NUM_PACKETS-1:0]                 curStart;
    logic [NUM_PACKETS-1:0]                 curStart32;

    IfPacket                 cycPkt [BUF_SIZE+1];
    Halfword [WINDOW_SIZE-1:0] window;
    logic [WINDOW_SIZE-1:0]  winStartRaw;
    logic [WINDOW_SIZE-1:0]  winStart;
    logic [WINDOW_SIZE-1:0]  winStart32;
    logic [WINDOW_SIZE-1:0]  unhandled;

    logic [IDX_W-1:0] pencIdx [NUM_INSTRS];
    logic             pencValid [NUM_INSTRS];
    PdInstr           instrC [NUM_INSTRS];

    logic outputReady;
    logic canShift;
    logic middleIsSplit32;
    logic lastIsSplit32;

    // Mark instruction starts in the incoming packet
    always_comb begin
        logic canStart;
        logic inRange;
        canStart = !(prevStart[BUF_SIZE-1][NUM_PACKETS-1]
                     && prevStart32[BUF_SIZE-1][NUM_PACKETS-1]);
        for (int i = 0; i < NUM_PACKETS; i++) begin
            inRange = packet.valid && FetchOff'(i) >= packet.firstValid
                      && FetchOff'(i) <= packet.lastValid;
            curStart[i] = 1'b0;
            curStart32[i] = 1'b0;
            if (inRange && canStart) begin
                curStart[i] = 1'b1;
                curStart32[i] = (packet.halfwords[i][1:0] == 2'b11);
                canStart = !curStart32[i];
            end else begin
                // Halfword after the upper half of a 32-bit instruction starts again
                canStart = 1'b1;
            end
        end
    end

    always_comb begin
        for (int c = 0; c <= BUF_SIZE; c++) begin
            cycPkt[c] = (c < BUF_SIZE) ? prevPkt[c] : packet;
            for (int j = 0; j < NUM_PACKETS; j++) begin
                window[c*NUM_PACKETS+j] = cycPkt[c].halfwords[j];
            end
        end
    end

    assign winStartRaw = {curStart, prevStart};
    assign winStart32 = {curStart32, prevStart32};

    // A 32-bit start at the window edge waits for its upper half
    assign middleIsSplit32 = prevStart32[BUF_SIZE-1][NUM_PACKETS-1] && !packet.valid;
    assign lastIsSplit32 = curStart[NUM_PACKETS-1] && curStart32[NUM_PACKETS-1];

    always_comb begin
        winStart = winStartRaw;
        winStart[MID] = winStartRaw[MID] && !middleIsSplit32;
        winStart[LAST] = winStartRaw[LAST] && !lastIsSplit32;
    end

    PriorityEncoder #(
        .WIDTH(WINDOW_SIZE),
        .NUM_OUT(NUM_INSTRS)
    ) encoder_i (
        .data(winStart),
        .idx(pencIdx),
        .idxValid(pencValid)
    );

    always_comb begin
        for (int i = 0; i < NUM_INSTRS; i++) begin
            logic [IDX_W-1:0] lo;
            logic [IDX_W-1:0] hi;
            logic             is32;
            lo = pencIdx[i];
            hi = (lo == IDX_W'(LAST)) ? lo : lo + 1'b1;
            is32 = winStart32[lo];
            instrC[i].valid = pencValid[i];
            instrC[i].pc = {cycPkt[lo/NUM_PACKETS].pc, FetchOff'(lo % NUM_PACKETS), 1'b0};
            instrC[i].instr = is32 ? {window[hi], window[lo]} : {16'h0000, window[lo]};
            instrC[i].is16bit = !is32;
        end
    end

    if (FF_OUTPUT != 0) begin : gOutReg
        logic [NUM_INSTRS-1:0] outValid;
        PdInstr                outData [NUM_INSTRS];

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                outValid <= '0;
            end else if (clear) begin
                outValid <= '0;
            end else if (outputReady) begin
                for (int i = 0; i < NUM_INSTRS; i++) begin
                    outValid[i] <= instrC[i].valid;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (outputReady) begin
                outData <= instrC;
            end
        end

        always_comb begin
            for (int i = 0; i < NUM_INSTRS; i++) begin
                instrs[i] = outData[i];
                instrs[i].valid = outValid[i];
            end
        end

        assign outputReady = !outValid[0] || ready;
    end else begin : gOutComb
        assign instrs = instrC;
        assign outputReady = ready;
    end

    // Starts above the last emitted instruction stay pending
    always_comb begin
        int lastEnd;
        lastEnd = int'(pencIdx[NUM_INSTRS-1]) + int'(winStart32[pencIdx[NUM_INSTRS-1]]);
        for (int i = 0; i < WINDOW_SIZE; i++) begin
            unhandled[i] = !outputReady || (pencValid[NUM_INSTRS-1] && i > lastEnd);
        end
        unhandled[MID] = unhandled[MID] || middleIsSplit32;
        unhandled[LAST] = unhandled[LAST] || lastIsSplit32;
    end

    assign canShift = !(|(unhandled[NUM_PACKETS-1:0] & winStart[NUM_PACKETS-1:0]));
    assign packetReady = packet.valid && canShift;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prevStart <= '0;
            prevStart32 <= '0;
        end else if (clear) begin
            prevStart <= '0;
            prevStart32 <= '0;
        end else if (packetReady) begin
            for (int i = 0; i < BUF_SIZE; i++) begin
                prevStart[i] <= winStartRaw[(i+1)*NUM_PACKETS +: NUM_PACKETS]
                                & unhandled[(i+1)*NUM_PACKETS +: NUM_PACKETS];
                prevStart32[i] <= winStart32[(i+1)*NUM_PACKETS +: NUM_PACKETS];
            end
        end else begin
            for (int i = 0; i < BUF_SIZE; i++) begin
                prevStart[i] <= prevStart[i] & unhandled[i*NUM_PACKETS +: NUM_PACKETS];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (packetReady) begin
            for (int i = 0; i < BUF_SIZE; i++) begin
                prevPkt[i] <= cycPkt[i+1];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/PacketFetcher.sv ====
`default_nettype none
`include "frontend_params.svh"

module PacketFetcher (
    input  logic              clk,
    input  logic              rst,
    input  FetchPkg::Redirect redirect,
    output FetchPkg::WbReq    busReq,
    input  FetchPkg::WbRsp    busRsp,
    output FetchPkg::IfPacket packet,
    input  logic              packetReady
);
    import FetchPkg::*;

    localparam int OFF_LSB = 1;
    localparam int ADR_LSB = OFF_LSB + $bits(FetchOff);
    localparam FetchAddr RESET_ADDR = `RESET_PC;

    FetchState state;
    PacketAddr fetchPc;
    FetchOff   startOff;
    PacketAddr busAdr;

    logic                       pktValid;
    PacketAddr                  pktPc;
    FetchOff                    pktFirst;
    Halfword [`NUM_PACKETS-1:0] pktHalfwords;

    logic      pktTaken;
    logic      issue;
    PacketAddr issueAdr;
    logic      rspTake;

    assign pktTaken = pktValid && packetReady;

    // New cycle once the holding register is free or empties this cycle
    assign issue = (state == fetchIdle) && (redirect.valid || !pktValid || packetReady);
    assign issueAdr = redirect.valid ? redirect.pc[31:ADR_LSB] : fetchPc;

    // Response data is only kept when no redirect has overtaken it
    assign rspTake = (state == fetchBusy) && busRsp.ack && !redirect.valid;

    assign busReq = '{
        cyc: (state != fetchIdle),
        stb: (state != fetchIdle),
        adr: busAdr
    };

    assign packet = '{
        valid:      pktValid,
        pc:         pktPc,
        firstValid: pktFirst,
        lastValid:  FetchOff'(`NUM_PACKETS - 1),
        halfwords:  pktHalfwords
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= fetchIdle;
            fetchPc  <= RESET_ADDR[31:ADR_LSB];
            startOff <= RESET_ADDR[ADR_LSB-1:OFF_LSB];
            pktValid <= 1'b0;
        end else begin
            unique case (state)
                fetchIdle: begin
                    if (issue) begin
                        state <= fetchBusy;
                    end
                end
                fetchBusy: begin
                    if (busRsp.ack) begin
                        state <= fetchIdle;
                    end else if (redirect.valid) begin
                        state <= fetchDrop;
                    end
                end
                fetchDrop: begin
                    // Stale cycle still has to finish on the bus
                    if (busRsp.ack) begin
                        state <= fetchIdle;
                    end
                end
                default: begin
                    state <= fetchIdle;
                end
            endcase

            if (redirect.valid) begin
                fetchPc  <= redirect.pc[31:ADR_LSB];
                startOff <= redirect.pc[ADR_LSB-1:OFF_LSB];
            end else if (rspTake) begin
                fetchPc  <= busAdr + 1'b1;
                startOff <= '0;
            end

            if (redirect.valid) begin
                pktValid <= 1'b0;
            end else if (rspTake) begin
                pktValid <= 1'b1;
            end else if (pktTaken) begin
                pktValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            busAdr <= issueAdr;
        end
        if (rspTake) begin
            pktPc        <= busAdr;
            pktFirst     <= startOff;
            pktHalfwords <= busRsp.dat;
        end
    end

endmodule

`default_nettype wire

// ==== source/PriorityEncoder.sv ====
`default_nettype none

module PriorityEncoder #(
    parameter int WIDTH = 8,
    parameter int NUM_OUT = 2,
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0] data,
    output logic [IDX_W-1:0] idx [NUM_OUT],
    output logic             idxValid [NUM_OUT]
);

    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = data;
        for (int k = 0; k < NUM_OUT; k++) begin
            idx[k] = '0;
            idxValid[k] = 1'b0;
            // Scan downwards so the lowest set bit wins
            for (int i = WIDTH - 1; i >= 0; i--) begin
                if (remaining[i]) begin
                    idx[k] = IDX_W'(i);
                    idxValid[k] = 1'b1;
                end
            end
            if (idxValid[k]) begin
                remaining[idx[k]] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/DecodePkg.sv ====
`default_nettype none

package DecodePkg;
    typedef logic [31:0] InstrWord;

    // Compressed instructions carry zero in the upper half of instr
    typedef struct packed {
        logic               valid;
        FetchPkg::FetchAddr pc;
        InstrWord           instr;
        logic               is16bit;
    } PdInstr;
endpackage

`default_nettype wire

// ==== source/FetchPkg.sv ====
`default_nettype none

package FetchPkg;
    `include "frontend_params.svh"

    typedef logic [31:0] FetchAddr;
    typedef logic [28:0] PacketAddr;
    typedef logic [1:0]  FetchOff;
    typedef logic [15:0] Halfword;

    typedef struct packed {
        logic      cyc;
        logic      stb;
        PacketAddr adr;
    } WbReq;

    typedef struct packed {
        logic                         ack;
        logic [`NUM_PACKETS*16-1:0] dat;
    } WbRsp;

    // lastValid is always the final halfword here, kept for the aligner range check
    typedef struct packed {
        logic                       valid;
        PacketAddr                  pc;
        FetchOff                    firstValid;
        FetchOff                    lastValid;
        Halfword [`NUM_PACKETS-1:0] halfwords;
    } IfPacket;

    typedef struct packed {
        logic     valid;
        FetchAddr pc;
    } Redirect;

    typedef enum logic [1:0] {
        fetchIdle,
        fetchBusy,
        fetchDrop
    } FetchState;
endpackage

`default_nettype wire

// ==== include/frontend_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Halfwords in one 64-bit fetch packet
`define NUM_PACKETS 4

// Instruction slots in one output group
`define NUM_INSTRS 2

// Earlier packets the aligner keeps in its window
`define BUF_SIZE 2

// Register the aligner output
`define FF_OUTPUT 1

`define RESET_PC 32'h0000_0000

`endif
